// File: hdl/crtc_reg_pkg.sv
package crtc_reg_pkg;

	// host register index, only the timing registers are decoded
	typedef enum logic [5:0] {
		ht    = 6'd0,  // horizontal total, minus 1
		hd    = 6'd1,  // horizontal displayed
		hp    = 6'd2,  // horizontal sync position
		syncw = 6'd3,  // vw in the high nibble, hw in the low nibble
		vt    = 6'd4,  // vertical total in rows, minus 1
		va    = 6'd5,  // vertical total adjust in scanlines
		vd    = 6'd6,  // vertical displayed rows
		vp    = 6'd7,  // vertical sync row
		ctv   = 6'd9,  // scanlines per row, minus 1
		cth   = 6'd22  // pixels per column, minus 1 (high nibble)
	} crtc_reg_e;

	// programmed timing as seen by the beam generator
	typedef struct packed {
		logic [7:0] ht;
		logic [7:0] hd;
		logic [7:0] hp;
		logic [3:0] hw;  // hsync width in columns
		logic [3:0] vw;  // vsync width in scanlines
		logic [7:0] vt;
		logic [4:0] va;
		logic [7:0] vd;
		logic [7:0] vp;
		logic [4:0] ctv;
		logic [3:0] cth;
	} crtc_regs_t;

	// small frame, 10 columns by 6 rows plus one adjust line
	localparam crtc_regs_t regs_reset = '{
		ht: 8'd9, hd: 8'd6, hp: 8'd7,
		hw: 4'd2, vw: 4'd1,
		vt: 8'd5, va: 5'd1, vd: 8'd4, vp: 8'd4,
		ctv: 5'd1, cth: 4'd1
	};

endpackage

// File: hdl/crtc_beam_pkg.sv
package crtc_beam_pkg;

	// single enabled-cycle events from the horizontal counter
	typedef struct packed {
		logic line_start;   // first pixel of column 0
		logic hsync_start;  // last pixel before the column that starts hsync
		logic line_end;     // last pixel of column ht
	} col_events_t;

	// current beam position
	typedef struct packed {
		logic [7:0] col;
		logic [7:0] row;
		logic [4:0] pixel;  // pixel within the character column
		logic [4:0] line;   // scanline within the character row
	} beam_pos_t;

	// levels and pulses for the video side
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic hblank;
		logic vblank;
		logic h_visible;
		logic v_visible;
		logic new_col;      // pulse, first pixel of a column
		logic end_col;      // pulse, last pixel of a column
		logic fetch_frame;  // pulse, start of frame
		logic fetch_row;    // pulse, start of visible row
		logic fetch_line;   // pulse, start of visible scanline
	} video_sync_t;

endpackage

// File: hdl/crtc_register_file.sv
module crtc_register_file (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [5:0]                reg_addr,  // register index
	input  logic [7:0]                reg_data,
	input  logic                      reg_we,    // one-cycle write strobe
	output crtc_reg_pkg::crtc_regs_t  regs
);

	always_ff @(posedge clk) begin
		if (reset) begin
			regs <= crtc_reg_pkg::regs_reset;
		end else if (reg_we) begin
			case (crtc_reg_pkg::crtc_reg_e'(reg_addr))
				crtc_reg_pkg::ht: begin
					regs.ht <= reg_data;
				end
				crtc_reg_pkg::hd: begin
					regs.hd <= reg_data;
				end
				crtc_reg_pkg::hp: begin
					regs.hp <= reg_data;
				end
				crtc_reg_pkg::syncw: begin
					regs.vw <= reg_data[7:4];  // vsync width, scanlines
					regs.hw <= reg_data[3:0];  // hsync width, columns
				end
				crtc_reg_pkg::vt: begin
					regs.vt <= reg_data;
				end
				crtc_reg_pkg::va: begin
					regs.va <= reg_data[4:0];
				end
				crtc_reg_pkg::vd: begin
					regs.vd <= reg_data;
				end
				crtc_reg_pkg::vp: begin
					regs.vp <= reg_data;
				end
				crtc_reg_pkg::ctv: begin
					regs.ctv <= reg_data[4:0];
				end
				crtc_reg_pkg::cth: begin
					// character width sits in the upper nibble, the lower one
					// holds the displayed width on the real chip
					regs.cth <= reg_data[7:4];
				end
				default: begin
					// unknown index, write dropped
				end
			endcase
		end
	end

endmodule

// File: hdl/crtc_horizontal.sv
module crtc_horizontal #(
	parameter int hb_front_porch = 2,  // columns from hd to blank start
	parameter int hb_width       = 3   // blank length in columns
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      enable,
	input  crtc_reg_pkg::crtc_regs_t  regs,
	output logic                      new_col,
	output logic                      end_col,
	output logic [7:0]                col,
	output logic [4:0]                pixel,
	output logic                      h_visible,
	output logic                      hsync,
	output logic                      hblank
);

	localparam int hb_end = hb_front_porch + hb_width;

	logic       running;     // set once the first enabled cycle after reset is done
	logic       pixel_last;  // at the last pixel of the column
	logic [7:0] col_next;
	logic [3:0] hs_cnt;      // hsync columns still to go
	logic       hb_run;      // porch or blank phase in progress
	logic [7:0] hb_cnt;      // columns since col reached hd
	logic [7:0] hb_step;

	assign pixel_last = pixel == {1'b0, regs.cth};
	assign col_next   = (col == regs.ht) ? 8'd0 : col + 8'd1;  // wraps after ht
	assign hb_step    = hb_cnt + 8'd1;

	assign new_col   = enable && running && pixel == 5'd0;
	assign end_col   = enable && running && pixel_last;
	assign h_visible = col < regs.hd;

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			pixel   <= 5'd0;
			col     <= 8'd0;
			hsync   <= 1'b0;
			hs_cnt  <= 4'd0;
			hblank  <= 1'b0;
			hb_run  <= 1'b0;
			hb_cnt  <= 8'd0;
		end else if (enable) begin
			running <= 1'b1;
			pixel   <= pixel_last ? 5'd0 : pixel + 5'd1;
			if (pixel_last) begin
				col <= col_next;

				// sync counts in whole columns, so it may run past the wrap
				if (col_next == regs.hp) begin
					hsync  <= regs.hw != 4'd0;
					hs_cnt <= regs.hw - 4'd1;
				end else if (hsync) begin
					if (hs_cnt == 4'd0)
						hsync <= 1'b0;
					else
						hs_cnt <= hs_cnt - 4'd1;
				end

				if (col_next == regs.hd) begin  // visible area just ended
					hb_run <= 1'b1;
					hb_cnt <= 8'd0;
					hblank <= hb_front_porch == 0 && hb_width > 0;
				end else if (hb_run) begin
					hb_cnt <= hb_step;
					hblank <= hb_step >= hb_front_porch && hb_step < hb_end;
					if (hb_step >= hb_end)
						hb_run <= 1'b0;  // blank done
				end
			end
		end
	end

endmodule

// File: hdl/crtc_vertical.sv
module crtc_vertical #(
	parameter int vb_front_porch = 1,  // scanlines from end of display to blank
	parameter int vb_width       = 2   // blank length in scanlines
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       enable,
	input  crtc_reg_pkg::crtc_regs_t   regs,
	input  crtc_beam_pkg::col_events_t events,
	output logic [4:0]                 line,
	output logic [7:0]                 row,
	output logic                       v_visible,
	output logic                       vsync,
	output logic                       vblank,
	output logic                       fetch_frame,
	output logic                       fetch_row,
	output logic                       fetch_line,
	output logic                       frame_end
);

	localparam int vb_end = vb_front_porch + vb_width;

	logic       adjust;       // in the va extra scanlines after row vt
	logic       adjust_next;
	logic [4:0] line_next;
	logic [7:0] row_next;
	logic [3:0] vs_cnt;       // vsync scanlines still to go
	logic       vb_run;
	logic [7:0] vb_cnt;       // scanlines since the visible rows ended
	logic [7:0] vb_step;
	logic       vb_start;

	// position after the current scanline ends
	always_comb begin
		line_next   = line + 5'd1;
		row_next    = row;
		adjust_next = adjust;
		frame_end   = 1'b0;
		if (adjust) begin
			if (line_next == regs.va) begin  // last adjust scanline
				line_next   = 5'd0;
				row_next    = 8'd0;
				adjust_next = 1'b0;
				frame_end   = events.line_end;
			end
		end else if (line == regs.ctv) begin
			line_next = 5'd0;
			if (row != regs.vt) begin
				row_next = row + 8'd1;
			end else if (regs.va != 5'd0) begin
				row_next    = row + 8'd1;  // adjust lines sit below row vt
				adjust_next = 1'b1;
			end else begin
				row_next  = 8'd0;
				frame_end = events.line_end;
			end
		end
	end

	assign vb_start = row_next != row && row_next == regs.vd;  // leaving the visible rows
	assign vb_step  = vb_cnt + 8'd1;

	assign v_visible   = row < regs.vd;
	assign fetch_frame = events.line_start && !adjust && row == 8'd0 && line == 5'd0;
	assign fetch_row   = events.line_start && !adjust && v_visible && line == 5'd0;
	assign fetch_line  = events.line_start && !adjust && v_visible;

	always_ff @(posedge clk) begin
		if (reset) begin
			line   <= 5'd0;
			row    <= 8'd0;
			adjust <= 1'b0;
			vsync  <= 1'b0;
			vs_cnt <= 4'd0;
			vblank <= 1'b0;
			vb_run <= 1'b0;
			vb_cnt <= 8'd0;
		end else if (enable) begin
			if (events.line_end) begin
				line   <= line_next;
				row    <= row_next;
				adjust <= adjust_next;
				if (vb_start) begin
					vb_run <= 1'b1;
					vb_cnt <= 8'd0;
					vblank <= vb_front_porch == 0 && vb_width > 0;
				end else if (vb_run) begin
					vb_cnt <= vb_step;
					vblank <= vb_step >= vb_front_porch && vb_step < vb_end;
					if (vb_step >= vb_end)
						vb_run <= 1'b0;
				end
			end

			// vsync edges line up with hsync rising
			if (events.hsync_start) begin
				if (!adjust && row == regs.vp && line == 5'd0) begin
					vsync  <= regs.vw != 4'd0;
					vs_cnt <= regs.vw - 4'd1;
				end else if (vsync) begin
					if (vs_cnt == 4'd0)
						vsync <= 1'b0;
					else
						vs_cnt <= vs_cnt - 4'd1;
				end
			end
		end
	end

endmodule

// File: hdl/crtc_beam.sv
module crtc_beam #(
	parameter int hb_front_porch = 2,
	parameter int hb_width       = 3,
	parameter int vb_front_porch = 1,
	parameter int vb_width       = 2
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       enable,
	input  crtc_reg_pkg::crtc_regs_t   regs,
	output crtc_beam_pkg::beam_pos_t   pos,
	output crtc_beam_pkg::video_sync_t sync,
	output logic [1:0]                 blink  // [0] every 8 frames, [1] every 15
);

	logic                       new_col;
	logic                       end_col;
	logic [7:0]                 col;
	logic [4:0]                 pixel;
	logic                       h_visible;
	logic                       hsync;
	logic                       hblank;
	logic [7:0]                 row;
	logic [4:0]                 line;
	logic                       v_visible;
	logic                       vsync;
	logic                       vblank;
	logic                       fetch_frame;
	logic                       fetch_row;
	logic                       fetch_line;
	logic                       frame_end;
	logic [7:0]                 hsync_col;  // column whose end starts hsync
	crtc_beam_pkg::col_events_t events;
	logic [2:0]                 bcnt16;     // low bits of the 1/16 divider
	logic [3:0]                 bcnt30;     // 0..14, toggles blink[1]

	assign hsync_col = (regs.hp != 8'd0) ? regs.hp - 8'd1 : regs.ht;

	assign events.line_start  = new_col && col == 8'd0;
	assign events.hsync_start = end_col && col == hsync_col;
	assign events.line_end    = end_col && col == regs.ht;

	crtc_horizontal #(
		.hb_front_porch(hb_front_porch),
		.hb_width      (hb_width)
	) horizontal (
		.clk      (clk),
		.reset    (reset),
		.enable   (enable),
		.regs     (regs),
		.new_col  (new_col),
		.end_col  (end_col),
		.col      (col),
		.pixel    (pixel),
		.h_visible(h_visible),
		.hsync    (hsync),
		.hblank   (hblank)
	);

	crtc_vertical #(
		.vb_front_porch(vb_front_porch),
		.vb_width      (vb_width)
	) vertical (
		.clk        (clk),
		.reset      (reset),
		.enable     (enable),
		.regs       (regs),
		.events     (events),
		.line       (line),
		.row        (row),
		.v_visible  (v_visible),
		.vsync      (vsync),
		.vblank     (vblank),
		.fetch_frame(fetch_frame),
		.fetch_row  (fetch_row),
		.fetch_line (fetch_line),
		.frame_end  (frame_end)
	);

	assign pos  = '{col: col, row: row, pixel: pixel, line: line};
	assign sync = '{hsync: hsync, vsync: vsync, hblank: hblank, vblank: vblank,
		h_visible: h_visible, v_visible: v_visible, new_col: new_col, end_col: end_col,
		fetch_frame: fetch_frame, fetch_row: fetch_row, fetch_line: fetch_line};

	always_ff @(posedge clk) begin
		if (reset) begin
			blink  <= 2'b00;
			bcnt16 <= 3'd0;
			bcnt30 <= 4'd0;
		end else if (frame_end) begin  // already qualified by enable
			{blink[0], bcnt16} <= {blink[0], bcnt16} + 4'd1;  // carry flips blink[0]
			if (bcnt30 == 4'd14) begin
				blink[1] <= ~blink[1];
				bcnt30   <= 4'd0;
			end else begin
				bcnt30 <= bcnt30 + 4'd1;
			end
		end
	end

endmodule

// File: hdl/crtc_top.sv
module crtc_top #(
	parameter int hb_front_porch = 2,  // horizontal blank porch, columns
	parameter int hb_width       = 3,
	parameter int vb_front_porch = 1,  // vertical blank porch, scanlines
	parameter int vb_width       = 2
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       enable,    // pixel clock enable
	input  logic [5:0]                 reg_addr,
	input  logic [7:0]                 reg_data,
	input  logic                       reg_we,
	output crtc_beam_pkg::beam_pos_t   pos,
	output crtc_beam_pkg::video_sync_t sync,
	output logic [1:0]                 blink
);

	crtc_reg_pkg::crtc_regs_t regs;  // held timing registers

	crtc_register_file register_file (
		.clk     (clk),
		.reset   (reset),
		.reg_addr(reg_addr),
		.reg_data(reg_data),
		.reg_we  (reg_we),
		.regs    (regs)
	);

	crtc_beam #(
		.hb_front_porch(hb_front_porch),
		.hb_width      (hb_width),
		.vb_front_porch(vb_front_porch),
		.vb_width      (vb_width)
	) beam (
		.clk   (clk),
		.reset (reset),
		.enable(enable),
		.regs  (regs),
		.pos   (pos),
		.sync  (sync),
		.blink (blink)
	);

endmodule

// File: test/crtc_props.sv
module crtc_props (
	input logic                       clk,
	input logic                       reset,
	input logic                       enable,
	input logic [5:0]                 reg_addr,
	input logic [7:0]                 reg_data,
	input logic                       reg_we,
	input crtc_reg_pkg::crtc_regs_t   regs,
	input crtc_beam_pkg::beam_pos_t   pos,
	input crtc_beam_pkg::video_sync_t sync,
	input logic [1:0]                 blink
);

	int         errors;     // failed assertions so far
	int         frames;     // fetch_frame pulses seen
	logic [1:0] quiet;      // frame starts still to pass after a register write
	logic       settled;    // timing registers stable for a whole frame
	logic [4:0] vs_lines;   // scanline ends seen while vsync is high
	logic       le;         // end of the last column of a scanline

	assign settled = quiet == 2'd0;
	assign le      = enable && sync.end_col && pos.col == regs.ht;

	function automatic int col_mod(int c, int last);
		return c % (last + 1);
	endfunction

	initial errors = 0;

	always_ff @(posedge clk) begin
		if (reset) begin
			frames   <= 0;
			quiet    <= 2'd0;
			vs_lines <= 5'd0;
		end else begin
			if (sync.fetch_frame)
				frames <= frames + 1;
			if (reg_we)
				quiet <= 2'd2;  // counters may still hold old-geometry state
			else if (sync.fetch_frame && quiet != 2'd0)
				quiet <= quiet - 2'd1;
			if (!sync.vsync)
				vs_lines <= 5'd0;
			else if (le)
				vs_lines <= vs_lines + 5'd1;
		end
	end

	a_reset: assert property (@(posedge clk) $past(reset) |-> pos == '0 && blink == 2'b00
		&& !sync.hsync && !sync.vsync && !sync.hblank && !sync.vblank && !sync.new_col
		&& !sync.end_col && !sync.fetch_frame && !sync.fetch_row && !sync.fetch_line)
		else begin $error("outputs not cleared after reset"); errors++; end

	a_pixel: assert property (@(posedge clk) disable iff (reset) !reset && enable |=>
		pos.pixel == (($past(pos.pixel) == $past(regs.cth)) ? 5'd0 : $past(pos.pixel) + 5'd1))
		else begin
			$error("Fail %0t pixel exp %0d got %0d", $time,
				($past(pos.pixel) == $past(regs.cth)) ? 5'd0 : $past(pos.pixel) + 5'd1,
				$sampled(pos.pixel));
			errors++;
		end

	a_hold: assert property (@(posedge clk) disable iff (reset) !reset && !enable |=>
		$stable(pos)) else begin $error("beam position moved with enable low"); errors++; end

	a_end_col: assert property (@(posedge clk) disable iff (reset)
		sync.end_col == (enable && pos.pixel == regs.cth))
		else begin
			$error("Fail %0t end_col exp %0b got %0b", $time,
				$sampled(enable && pos.pixel == regs.cth), $sampled(sync.end_col));
			errors++;
		end

	a_new_col: assert property (@(posedge clk) disable iff (reset)
		sync.new_col |-> enable && pos.pixel == 5'd0)
		else begin $error("new_col away from pixel 0"); errors++; end

	// also covers the register write to ht, the wrap uses the value of that cycle
	a_col: assert property (@(posedge clk) disable iff (reset) !reset && sync.end_col |=>
		pos.col == (($past(pos.col) == $past(regs.ht)) ? 8'd0 : $past(pos.col) + 8'd1))
		else begin
			$error("Fail %0t col exp %0d got %0d", $time,
				($past(pos.col) == $past(regs.ht)) ? 8'd0 : $past(pos.col) + 8'd1,
				$sampled(pos.col));
			errors++;
		end

	a_col_hold: assert property (@(posedge clk) disable iff (reset)
		!reset && !sync.end_col |=> $stable(pos.col))
		else begin $error("column moved without end_col"); errors++; end

	a_ht_write: assert property (@(posedge clk) disable iff (reset)
		reg_we && reg_addr == 6'd0 |=> regs.ht == $past(reg_data))
		else begin
			$error("Fail %0t ht exp %0d got %0d", $time, $past(reg_data), $sampled(regs.ht));
			errors++;
		end

	a_h_visible: assert property (@(posedge clk) disable iff (reset)
		sync.h_visible == (pos.col < regs.hd))
		else begin
			$error("Fail %0t h_visible exp %0b got %0b", $time, $sampled(pos.col < regs.hd),
				$sampled(sync.h_visible));
			errors++;
		end

	a_hsync_on: assert property (@(posedge clk) disable iff (reset)
		settled && $rose(sync.hsync) |-> pos.col == regs.hp)
		else begin $error("hsync rose away from hp"); errors++; end

	a_hsync_off: assert property (@(posedge clk) disable iff (reset)
		settled && $fell(sync.hsync) |-> pos.col == col_mod(regs.hp + regs.hw, regs.ht))
		else begin $error("hsync width is not hw columns"); errors++; end

	a_hblank_on: assert property (@(posedge clk) disable iff (reset) settled
		&& $rose(sync.hblank) |-> pos.col == col_mod(regs.hd + 2, regs.ht))
		else begin $error("hblank started at the wrong column"); errors++; end

	a_hblank_off: assert property (@(posedge clk) disable iff (reset) settled
		&& $fell(sync.hblank) |-> pos.col == col_mod(regs.hd + 5, regs.ht))
		else begin $error("hblank ended at the wrong column"); errors++; end

	a_vhold: assert property (@(posedge clk) disable iff (reset)
		!reset && !le |=> $stable(pos.row) && $stable(pos.line))
		else begin $error("row or line moved outside a line end"); errors++; end

	a_line: assert property (@(posedge clk) disable iff (reset) settled && le
		&& pos.row <= regs.vt |=>
		pos.line == (($past(pos.line) == $past(regs.ctv)) ? 5'd0 : $past(pos.line) + 5'd1))
		else begin
			$error("Fail %0t line exp %0d got %0d", $time,
				($past(pos.line) == $past(regs.ctv)) ? 5'd0 : $past(pos.line) + 5'd1,
				$sampled(pos.line));
			errors++;
		end

	a_row: assert property (@(posedge clk) disable iff (reset) settled && le
		&& pos.row <= regs.vt && pos.line == regs.ctv |=>
		pos.row == (($past(pos.row) == $past(regs.vt) && $past(regs.va) == 5'd0)
		? 8'd0 : $past(pos.row) + 8'd1))
		else begin
			$error("Fail %0t row exp %0d got %0d", $time,
				($past(pos.row) == $past(regs.vt) && $past(regs.va) == 5'd0)
				? 8'd0 : $past(pos.row) + 8'd1, $sampled(pos.row));
			errors++;
		end

	// adjust scanlines live in row vt + 1
	a_adjust: assert property (@(posedge clk) disable iff (reset) settled && le
		&& pos.row == regs.vt + 8'd1 |=> ($past(pos.line) + 1 == $past(regs.va))
		? (pos.row == 8'd0 && pos.line == 5'd0)
		: (pos.line == $past(pos.line) + 5'd1 && pos.row == $past(pos.row)))
		else begin $error("adjust scanlines out of order"); errors++; end

	a_v_visible: assert property (@(posedge clk) disable iff (reset)
		sync.v_visible == (pos.row < regs.vd))
		else begin
			$error("Fail %0t v_visible exp %0b got %0b", $time, $sampled(pos.row < regs.vd),
				$sampled(sync.v_visible));
			errors++;
		end

	a_vsync_on: assert property (@(posedge clk) disable iff (reset) settled
		&& $rose(sync.vsync) |-> pos.row == regs.vp && pos.line == 5'd0)
		else begin $error("vsync rose outside row vp line 0"); errors++; end

	a_vsync_off: assert property (@(posedge clk) disable iff (reset) settled
		&& $fell(sync.vsync) |-> vs_lines == regs.vw)
		else begin
			$error("Fail %0t vsync_lines exp %0d got %0d", $time, $sampled(regs.vw),
				$sampled(vs_lines));
			errors++;
		end

	// vblank position in scanlines from the top of the frame, adjust lines included
	a_vblank_on: assert property (@(posedge clk) disable iff (reset) settled
		&& $rose(sync.vblank) |-> pos.row * (regs.ctv + 1) + pos.line
		== (regs.vd * (regs.ctv + 1) + 1) % ((regs.vt + 1) * (regs.ctv + 1) + regs.va))
		else begin $error("vblank started at the wrong scanline"); errors++; end

	a_vblank_off: assert property (@(posedge clk) disable iff (reset) settled
		&& $fell(sync.vblank) |-> pos.row * (regs.ctv + 1) + pos.line
		== (regs.vd * (regs.ctv + 1) + 3) % ((regs.vt + 1) * (regs.ctv + 1) + regs.va))
		else begin $error("vblank ended at the wrong scanline"); errors++; end

	a_fetch_frame: assert property (@(posedge clk) sync.fetch_frame |->
		pos.col == 8'd0 && pos.row == 8'd0 && pos.line == 5'd0 && pos.pixel == 5'd0)
		else begin $error("fetch_frame away from position zero"); errors++; end

	a_fetch_row: assert property (@(posedge clk) sync.fetch_row |->
		pos.row < regs.vd && pos.line == 5'd0 && pos.col == 8'd0)
		else begin $error("fetch_row outside a visible row start"); errors++; end

	a_fetch_line: assert property (@(posedge clk) sync.fetch_line |->
		pos.row < regs.vd && pos.col == 8'd0)
		else begin $error("fetch_line outside the visible rows"); errors++; end

	// frame 0 after reset has no fetch_frame, so the count equals finished frames
	a_blink: assert property (@(posedge clk) disable iff (reset) sync.fetch_frame |->
		blink[0] == (((frames + 1) / 8) % 2) && blink[1] == (((frames + 1) / 15) % 2))
		else begin
			$error("Fail %0t blink exp %0d%0d got %b", $time, ((frames + 1) / 15) % 2,
				((frames + 1) / 8) % 2, $sampled(blink));
			errors++;
		end

endmodule

// File: test/tb_crtc.sv
module tb_crtc;

	localparam int frame_a = 260;  // enabled cycles per frame, reset geometry
	localparam int frame_b = 828;  // enabled cycles per frame, second geometry
	localparam int frames_a = 20;
	localparam int frames_b = 10;
	localparam int limit = ((frames_a + 1) * frame_a + (frames_b + 2) * frame_b) * 4 + 2000;
	localparam int unsigned seed = 5;

	logic                       clk;
	logic                       reset;
	logic                       enable;
	logic [5:0]                 reg_addr;
	logic [7:0]                 reg_data;
	logic                       reg_we;
	crtc_beam_pkg::beam_pos_t   pos;
	crtc_beam_pkg::video_sync_t sync;
	logic [1:0]                 blink;

	crtc_top i_dut (
		.clk     (clk),
		.reset   (reset),
		.enable  (enable),
		.reg_addr(reg_addr),
		.reg_data(reg_data),
		.reg_we  (reg_we),
		.pos     (pos),
		.sync    (sync),
		.blink   (blink)
	);

	bind crtc_top crtc_props props (
		.clk(clk), .reset(reset), .enable(enable), .reg_addr(reg_addr),
		.reg_data(reg_data), .reg_we(reg_we), .regs(regs), .pos(pos),
		.sync(sync), .blink(blink)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// pixel enable, high about three cycles in four
	initial begin
		void'($urandom(seed));
		forever begin
			@(posedge clk);
			#5;
			enable = ($urandom % 4) != 0;
		end
	end

	// first failing assertion ends the run
	always @(negedge clk) begin
		if (i_dut.props.errors != 0) begin
			$display("Errors found");
			$fatal(1, "assertion failure in the property module");
		end
	end

	initial begin
		#(limit * 40);
		$display("Errors found");
		$fatal(1, "watchdog timeout, frames did not complete");
	end

	task automatic wait_frames(input int n);
		repeat (n) begin
			@(negedge clk);
			while (!sync.fetch_frame)
				@(negedge clk);
		end
	endtask

	task automatic write_reg(input logic [5:0] addr, input logic [7:0] data);
		@(posedge clk);
		#5;
		reg_addr = addr;
		reg_data = data;
		reg_we   = 1'b1;
		@(posedge clk);
		#5;
		reg_we   = 1'b0;
	endtask

	initial begin
		reset    = 1'b1;
		enable   = 1'b0;
		reg_addr = 6'd0;
		reg_data = 8'd0;
		reg_we   = 1'b0;
		repeat (8) @(posedge clk);
		#5;
		reset = 1'b0;
		wait_frames(frames_a);
		// every value grows, so no counter ends up past its new limit
		write_reg(6'd0, 8'd11);    // ht
		write_reg(6'd1, 8'd8);     // hd
		write_reg(6'd2, 8'd9);     // hp
		write_reg(6'd3, 8'h23);    // vw 2, hw 3
		write_reg(6'd4, 8'd6);     // vt
		write_reg(6'd5, 8'd2);     // va
		write_reg(6'd6, 8'd5);     // vd
		write_reg(6'd7, 8'd5);     // vp
		write_reg(6'd9, 8'd2);     // ctv
		write_reg(6'd22, 8'h20);   // cth 2
		wait_frames(frames_b);
		@(negedge clk);
		if (i_dut.props.errors == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1, "assertion failures at end of run");
		end
	end

endmodule

// File: files.f
hdl/crtc_reg_pkg.sv
hdl/crtc_beam_pkg.sv
hdl/crtc_register_file.sv
hdl/crtc_horizontal.sv
hdl/crtc_vertical.sv
hdl/crtc_beam.sv
hdl/crtc_top.sv
test/crtc_props.sv
test/tb_crtc.sv

// File: Bender.yml
package:
  name: crtc

sources:
  - hdl/crtc_reg_pkg.sv
  - hdl/crtc_beam_pkg.sv
  - hdl/crtc_register_file.sv
  - hdl/crtc_horizontal.sv
  - hdl/crtc_vertical.sv
  - hdl/crtc_beam.sv
  - hdl/crtc_top.sv
  - target: simulation
    files:
      - test/crtc_props.sv
      - test/tb_crtc.sv
